//--- project.f
src/tile_pkg.sv
src/config_decoder.sv
src/connect_box.sv
src/switch_box.sv
src/logic_block.sv
src/pe_tile.sv
verification/pe_tile_props.sv
verification/pe_tile_tb.sv

//--- Bender.yml
package:
  name: pe_tile

sources:
  - src/tile_pkg.sv
  - src/config_decoder.sv
  - src/connect_box.sv
  - src/switch_box.sv
  - src/logic_block.sv
  - src/pe_tile.sv
  - target: simulation
    files:
      - verification/pe_tile_props.sv
      - verification/pe_tile_tb.sv

//--- verification/pe_tile_tb.sv
`timescale 1ns/100ps

module pe_tile_tb;

	import tile_pkg::*;

	localparam logic [15:0] tile_id = 16'h0023;
	localparam int max_cycles = 2000;

	logic clk;
	logic arst_n;
	logic config_req;
	logic [31:0] config_addr;
	logic [31:0] config_data;
	logic config_ack;
	logic [3:0] in_wire_0;
	logic [3:0] in_wire_1;
	logic [3:0] in_wire_2;
	logic [3:0] in_wire_3;
	logic [3:0] out_wire_0;
	logic [3:0] out_wire_1;
	logic [3:0] out_wire_2;
	logic [3:0] out_wire_3;

	// reference copies of the tile configuration
	logic [31:0] model_sb;
	logic [2:0] model_cb0;
	logic [2:0] model_cb1;
	logic [1:0] model_op;
	logic model_pe;
	logic [15:0] expected_out;

	logic check_en;
	logic [31:0] rand_state = 32'd32541;
	int error_count = 0;
	int test_start_errors = 0;
	int tests_run = 0;
	int tests_failed = 0;
	int cycle_count = 0;
	int props_failures;
	logic [31:0] r;
	logic [31:0] sb_word;
	logic [1:0] t0;
	logic [1:0] t1;

	pe_tile #(
		.TILE_ID(tile_id)
	) dut0 (
		.clk(clk),
		.arst_n(arst_n),
		.config_req(config_req),
		.config_addr(config_addr),
		.config_data(config_data),
		.config_ack(config_ack),
		.in_wire_0(in_wire_0),
		.in_wire_1(in_wire_1),
		.in_wire_2(in_wire_2),
		.in_wire_3(in_wire_3),
		.out_wire_0(out_wire_0),
		.out_wire_1(out_wire_1),
		.out_wire_2(out_wire_2),
		.out_wire_3(out_wire_3)
	);

	bind config_decoder pe_tile_props props0 (
		.clk(clk),
		.arst_n(arst_n),
		.req(req),
		.ack(ack),
		.sb_cfg_en(sb_cfg_en),
		.cb0_cfg_en(cb0_cfg_en),
		.cb1_cfg_en(cb1_cfg_en),
		.lb_cfg_en(lb_cfg_en)
	);

	always #20 clk = ~clk;

	function automatic logic [31:0] lcg_step();
		rand_state = rand_state * 32'd1664525 + 32'd1013904223;
		return rand_state;
	endfunction

	// upper halves of two lcg steps
	function automatic logic [31:0] random_word();
		logic [31:0] hi;
		logic [31:0] lo;
		hi = lcg_step();
		lo = lcg_step();
		return {hi[31:16], lo[31:16]};
	endfunction

	// out side s takes the other sides in increasing order
	function automatic logic [15:0] route_outputs(input logic [3:0] i0, i1, i2, i3,
			input logic pe, input logic [31:0] sel);
		logic [15:0] all_in;
		logic [15:0] res;
		logic [1:0] f;
		int src;
		all_in = {i3, i2, i1, i0};
		res = '0;
		for (int s = 0; s < 4; s++) begin
			for (int t = 0; t < 4; t++) begin
				f = sel[(s * 4 + t) * 2 +: 2];
				src = f;
				if (src >= s)
					src = src + 1;
				res[s * 4 + t] = (f == 2'd3) ? pe : all_in[src * 4 + t];
			end
		end
		return res;
	endfunction

	function automatic logic pick_operand(input logic [3:0] in_k, input logic [3:0] out_k,
			input logic [2:0] sel);
		return sel[2] ? out_k[sel[1:0]] : in_k[sel[1:0]];
	endfunction

	function automatic logic apply_op(input logic [1:0] op, input logic a, input logic b);
		case (op)
			op_and: return a & b;
			op_or: return a | b;
			op_xor: return a ^ b;
			default: return ~(a & b);
		endcase
	endfunction

	function automatic logic predict_pe(input logic [3:0] i0, i1, i2, i3, input logic pe);
		logic [15:0] routed;
		logic a;
		logic b;
		routed = route_outputs(i0, i1, i2, i3, pe, model_sb);
		a = pick_operand(i0, routed[3:0], model_cb0);
		b = pick_operand(i1, routed[7:4], model_cb1);
		return apply_op(model_op, a, b);
	endfunction

	task automatic check_value(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		if (actual !== expected) begin
			error_count++;
			$display("CHECK FAILED %s expected %h actual %h", name, expected, actual);
		end
	endtask

	task automatic drive_random_inputs(input int n);
		logic [31:0] w;
		repeat (n) begin
			@(posedge clk);
			w = random_word();
			in_wire_0 <= w[3:0];
			in_wire_1 <= w[7:4];
			in_wire_2 <= w[11:8];
			in_wire_3 <= w[15:12];
		end
	endtask

	// four-phase write with the model updated on the capture edge
	task automatic write_config(input logic [15:0] target, input logic [15:0] id,
			input logic [31:0] data);
		int waited;
		@(posedge clk);
		config_req <= 1'b1;
		config_addr <= {target, id};
		config_data <= data;
		@(negedge clk);
		check_value("config_ack", 0, config_ack);
		waited = 0;
		while (!config_ack && waited < 10) begin
			@(negedge clk);
			waited++;
		end
		if (!config_ack) begin
			error_count++;
			$display("config write to %h got no acknowledge", {target, id});
		end
		@(posedge clk);
		config_req <= 1'b0;
		if (id == tile_id) begin
			case (target)
				target_sb: model_sb = data;
				target_cb0: model_cb0 = data[2:0];
				target_cb1: model_cb1 = data[2:0];
				target_lb: model_op = data[1:0];
				default: ;
			endcase
		end
		// ack is held until req is sampled low
		@(negedge clk);
		check_value("config_ack", 1, config_ack);
		waited = 0;
		while (config_ack && waited < 10) begin
			@(negedge clk);
			waited++;
		end
		if (config_ack) begin
			error_count++;
			$display("config_ack stayed high after the request was dropped");
		end
	endtask

	task automatic finish_test(input string name);
		int n;
		n = error_count - test_start_errors;
		tests_run++;
		if (n != 0)
			tests_failed++;
		$display("test %s done with %0d errors", name, n);
		test_start_errors = error_count;
	endtask

	always @(negedge clk) begin
		if (check_en) begin
			expected_out = route_outputs(in_wire_0, in_wire_1, in_wire_2, in_wire_3,
				model_pe, model_sb);
			check_value("out_wire_0", expected_out[3:0], out_wire_0);
			check_value("out_wire_1", expected_out[7:4], out_wire_1);
			check_value("out_wire_2", expected_out[11:8], out_wire_2);
			check_value("out_wire_3", expected_out[15:12], out_wire_3);
			check_value("pe_out", model_pe, dut0.pe_out);
			model_pe = predict_pe(in_wire_0, in_wire_1, in_wire_2, in_wire_3, model_pe);
		end
	end

	always @(posedge clk) begin
		cycle_count++;
		if (cycle_count >= max_cycles) begin
			$display("timeout: the run did not finish within %0d cycles", max_cycles);
			$display("Some tests failed");
			$finish;
		end
	end

	initial begin
		clk = 1'b0;
		arst_n = 1'b0;
		config_req = 1'b0;
		config_addr = '0;
		config_data = '0;
		in_wire_0 = '0;
		in_wire_1 = '0;
		in_wire_2 = '0;
		in_wire_3 = '0;
		check_en = 1'b0;
		model_sb = '0;
		model_cb0 = '0;
		model_cb1 = '0;
		model_op = op_and;
		model_pe = 1'b0;
		repeat (3) @(posedge clk);
		arst_n <= 1'b1;
		check_en <= 1'b1;
		@(negedge clk);

		// selects at 0 pick the lowest other side
		check_value("config_ack", 0, config_ack);
		repeat (20) begin
			drive_random_inputs(1);
			@(negedge clk);
			check_value("out_wire_0", in_wire_1, out_wire_0);
			check_value("out_wire_1", in_wire_0, out_wire_1);
			check_value("out_wire_2", in_wire_0, out_wire_2);
			check_value("out_wire_3", in_wire_0, out_wire_3);
		end
		finish_test("reset_defaults");

		write_config(target_sb, 16'h0024, random_word());
		write_config(16'h0003, tile_id, random_word());
		write_config(16'h0000, tile_id, random_word());
		write_config(target_lb, 16'h1023, random_word());
		drive_random_inputs(10);
		write_config(target_cb0, tile_id, random_word());
		drive_random_inputs(5);
		finish_test("handshake");

		repeat (30) begin
			write_config(target_sb, tile_id, random_word());
			drive_random_inputs(10);
		end
		finish_test("switch_routing");

		for (int k = 0; k < 4; k++) begin
			// side 2 track 0 carries pe_out
			write_config(target_sb, tile_id, random_word() | 32'h0003_0000);
			write_config(target_cb0, tile_id, random_word());
			write_config(target_cb1, tile_id, random_word());
			write_config(target_lb, tile_id, 32'(k));
			drive_random_inputs(10);
		end
		finish_test("operand_ops");

		for (int k = 0; k < 4; k++) begin
			r = random_word();
			t0 = r[1:0];
			t1 = r[3:2];
			sb_word = random_word();
			sb_word[t0 * 2 +: 2] = 2'b11;
			sb_word[(4 + t1) * 2 +: 2] = 2'b11;
			write_config(target_sb, tile_id, sb_word);
			write_config(target_cb0, tile_id, {29'd0, 1'b1, t0});
			write_config(target_cb1, tile_id, {29'd0, 1'b1, t1});
			write_config(target_lb, tile_id, 32'(3 - k));
			drive_random_inputs(20);
		end
		finish_test("pe_loop");

		@(negedge clk);
		props_failures = dut0.decoder.props0.failures;
		$display("tests run %0d, tests failed %0d, check errors %0d, assertion failures %0d",
			tests_run, tests_failed, error_count, props_failures);
		if (error_count == 0 && props_failures == 0) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

endmodule

//--- verification/pe_tile_props.sv
`timescale 1ns/100ps

module pe_tile_props (
	input logic clk,
	input logic arst_n,
	input logic req,
	input logic ack,
	input logic sb_cfg_en,
	input logic cb0_cfg_en,
	input logic cb1_cfg_en,
	input logic lb_cfg_en
);

	logic [3:0] en_vec;
	int failures = 0;

	assign en_vec = {sb_cfg_en, cb0_cfg_en, cb1_cfg_en, lb_cfg_en};

	ack_rise_on_req: assert property (@(posedge clk) disable iff (!arst_n)
		$rose(ack) |-> $past(req)) else begin
		failures++;
		$error("ack rose without a request");
	end

	ack_fall_after_req: assert property (@(posedge clk) disable iff (!arst_n)
		$fell(ack) |-> $past(!req)) else begin
		failures++;
		$error("ack fell while the request was still high");
	end

	// decode targets are exclusive
	one_enable: assert property (@(posedge clk) disable iff (!arst_n)
		$onehot0(en_vec)) else begin
		failures++;
		$error("more than one block enable high");
	end

	enable_pulse: assert property (@(posedge clk) disable iff (!arst_n)
		(|en_vec) |=> !(|en_vec)) else begin
		failures++;
		$error("block enable held longer than one cycle");
	end

endmodule

//--- src/pe_tile.sv
`timescale 1ns/100ps

module pe_tile #(
	parameter logic [tile_pkg::tile_id_w-1:0] TILE_ID = '0
) (
	input logic clk,
	input logic arst_n,
	input logic config_req,
	input logic [tile_pkg::cfg_addr_w-1:0] config_addr,
	input logic [tile_pkg::cfg_data_w-1:0] config_data,
	output logic config_ack,
	input logic [tile_pkg::num_tracks-1:0] in_wire_0,
	input logic [tile_pkg::num_tracks-1:0] in_wire_1,
	input logic [tile_pkg::num_tracks-1:0] in_wire_2,
	input logic [tile_pkg::num_tracks-1:0] in_wire_3,
	output logic [tile_pkg::num_tracks-1:0] out_wire_0,
	output logic [tile_pkg::num_tracks-1:0] out_wire_1,
	output logic [tile_pkg::num_tracks-1:0] out_wire_2,
	output logic [tile_pkg::num_tracks-1:0] out_wire_3
);

	import tile_pkg::*;

	logic sb_cfg_en;
	logic cb0_cfg_en;
	logic cb1_cfg_en;
	logic lb_cfg_en;
	logic op_0;
	logic op_1;
	logic pe_out;

	config_decoder #(
		.TILE_ID(TILE_ID)
	) decoder (
		.clk(clk),
		.arst_n(arst_n),
		.req(config_req),
		.addr(config_addr),
		.ack(config_ack),
		.sb_cfg_en(sb_cfg_en),
		.cb0_cfg_en(cb0_cfg_en),
		.cb1_cfg_en(cb1_cfg_en),
		.lb_cfg_en(lb_cfg_en)
	);

	// operand 0 from side 0 tracks
	connect_box cb0 (
		.clk(clk),
		.arst_n(arst_n),
		.tracks({out_wire_0, in_wire_0}),
		.cfg_en(cb0_cfg_en),
		.cfg_data(config_data[cb_sel_w-1:0]),
		.block_out(op_0)
	);

	// operand 1 from side 1 tracks
	connect_box cb1 (
		.clk(clk),
		.arst_n(arst_n),
		.tracks({out_wire_1, in_wire_1}),
		.cfg_en(cb1_cfg_en),
		.cfg_data(config_data[cb_sel_w-1:0]),
		.block_out(op_1)
	);

	switch_box sb (
		.clk(clk),
		.arst_n(arst_n),
		.in_wire_0(in_wire_0),
		.in_wire_1(in_wire_1),
		.in_wire_2(in_wire_2),
		.in_wire_3(in_wire_3),
		.pe_out(pe_out),
		.cfg_en(sb_cfg_en),
		.cfg_data(config_data),
		.out_wire_0(out_wire_0),
		.out_wire_1(out_wire_1),
		.out_wire_2(out_wire_2),
		.out_wire_3(out_wire_3)
	);

	logic_block compute_block (
		.clk(clk),
		.arst_n(arst_n),
		.in0(op_0),
		.in1(op_1),
		.cfg_en(lb_cfg_en),
		.cfg_data(config_data[$bits(lb_op_e)-1:0]),
		.result(pe_out)
	);

endmodule

//--- src/logic_block.sv
`timescale 1ns/100ps

module logic_block (
	input logic clk,
	input logic arst_n,
	input logic in0,
	input logic in1,
	input logic cfg_en,
	input logic [$bits(tile_pkg::lb_op_e)-1:0] cfg_data,
	output logic result
);

	import tile_pkg::*;

	lb_op_e op_q;
	logic op_val;

	// opcode register
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			op_q <= op_and;
		end else if (cfg_en) begin
			op_q <= lb_op_e'(cfg_data);
		end
	end

	always_comb begin
		op_val = 1'b0;
		case (op_q)
			op_and: op_val = in0 & in1;
			op_or: op_val = in0 | in1;
			op_xor: op_val = in0 ^ in1;
			op_nand: op_val = ~(in0 & in1);
			default: op_val = 1'b0;
		endcase
	end

	// result register breaks the loop through the switch box
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			result <= 1'b0;
		end else begin
			result <= op_val;
		end
	end

endmodule

//--- src/switch_box.sv
`timescale 1ns/100ps

module switch_box (
	input logic clk,
	input logic arst_n,
	input logic [tile_pkg::num_tracks-1:0] in_wire_0,
	input logic [tile_pkg::num_tracks-1:0] in_wire_1,
	input logic [tile_pkg::num_tracks-1:0] in_wire_2,
	input logic [tile_pkg::num_tracks-1:0] in_wire_3,
	input logic pe_out,
	input logic cfg_en,
	input logic [tile_pkg::cfg_data_w-1:0] cfg_data,
	output logic [tile_pkg::num_tracks-1:0] out_wire_0,
	output logic [tile_pkg::num_tracks-1:0] out_wire_1,
	output logic [tile_pkg::num_tracks-1:0] out_wire_2,
	output logic [tile_pkg::num_tracks-1:0] out_wire_3
);

	import tile_pkg::*;

	localparam int num_sides = 4;

	logic [cfg_data_w-1:0] sel_q;
	logic [num_tracks-1:0] in_side [num_sides];
	logic [num_tracks-1:0] out_side [num_sides];

	// select register with two bits per output track
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			sel_q <= '0;
		end else if (cfg_en) begin
			sel_q <= cfg_data;
		end
	end

	assign in_side[0] = in_wire_0;
	assign in_side[1] = in_wire_1;
	assign in_side[2] = in_wire_2;
	assign in_side[3] = in_wire_3;

	for (genvar s = 0; s < num_sides; s++) begin : g_side
		// other sides in increasing order without side s
		localparam int other_0 = (s == 0) ? 1 : 0;
		localparam int other_1 = (s <= 1) ? 2 : 1;
		localparam int other_2 = (s <= 2) ? 3 : 2;

		for (genvar t = 0; t < num_tracks; t++) begin : g_track
			localparam int field = (s * num_tracks + t) * sb_sel_w;

			logic [sb_sel_w-1:0] sel;
			logic [2**sb_sel_w-1:0] cand;

			assign sel = sel_q[field +: sb_sel_w];

			// value 3 takes the processing element output
			assign cand = {
				pe_out,
				in_side[other_2][t],
				in_side[other_1][t],
				in_side[other_0][t]
			};

			assign out_side[s][t] = cand[sel];
		end
	end

	assign out_wire_0 = out_side[0];
	assign out_wire_1 = out_side[1];
	assign out_wire_2 = out_side[2];
	assign out_wire_3 = out_side[3];

endmodule

//--- src/connect_box.sv
`timescale 1ns/100ps

module connect_box (
	input logic clk,
	input logic arst_n,
	input logic [2*tile_pkg::num_tracks-1:0] tracks,
	input logic cfg_en,
	input logic [tile_pkg::cb_sel_w-1:0] cfg_data,
	output logic block_out
);

	import tile_pkg::*;

	logic [cb_sel_w-1:0] sel_q;

	// select register
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			sel_q <= '0;
		end else if (cfg_en) begin
			sel_q <= cfg_data;
		end
	end

	// input tracks at 0..3 and switch box outputs at 4..7
	assign block_out = tracks[sel_q];

endmodule

//--- src/config_decoder.sv
`timescale 1ns/100ps

module config_decoder #(
	parameter logic [tile_pkg::tile_id_w-1:0] TILE_ID = '0
) (
	input logic clk,
	input logic arst_n,
	input logic req,
	input logic [tile_pkg::cfg_addr_w-1:0] addr,
	output logic ack,
	output logic sb_cfg_en,
	output logic cb0_cfg_en,
	output logic cb1_cfg_en,
	output logic lb_cfg_en
);

	import tile_pkg::*;

	typedef enum logic {
		st_idle,
		st_acked
	} state_e;

	state_e state_q;
	logic [tile_id_w-1:0] addr_id;
	logic [cfg_addr_w-tile_id_w-1:0] addr_target;
	logic hit;

	assign addr_id = addr[tile_id_w-1:0];
	assign addr_target = addr[cfg_addr_w-1:tile_id_w];

	// new request for this tile while idle
	assign hit = (state_q == st_idle) && req && (addr_id == TILE_ID);

	// four-phase handshake
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state_q <= st_idle;
		end else begin
			case (state_q)
				st_idle: if (req) state_q <= st_acked;
				st_acked: if (!req) state_q <= st_idle;
				default: state_q <= st_idle;
			endcase
		end
	end

	assign ack = (state_q == st_acked);

	// enables last one cycle since hit needs idle
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			sb_cfg_en <= 1'b0;
			cb0_cfg_en <= 1'b0;
			cb1_cfg_en <= 1'b0;
			lb_cfg_en <= 1'b0;
		end else begin
			sb_cfg_en <= hit && (addr_target == target_sb);
			cb0_cfg_en <= hit && (addr_target == target_cb0);
			cb1_cfg_en <= hit && (addr_target == target_cb1);
			lb_cfg_en <= hit && (addr_target == target_lb);
		end
	end

endmodule

//--- src/tile_pkg.sv
package tile_pkg;

	// routing tracks on each tile side
	parameter int num_tracks = 4;

	// configuration port widths
	parameter int cfg_addr_w = 32;
	parameter int cfg_data_w = 32;

	// lower half of the address carries the tile id
	parameter int tile_id_w = 16;

	// upper half of the address selects the block
	typedef enum logic [15:0] {
		target_lb = 16'd4,
		target_cb1 = 16'd5,
		target_cb0 = 16'd6,
		target_sb = 16'd7
	} cfg_target_e;

	// logic block operations
	typedef enum logic [1:0] {
		op_and = 2'd0,
		op_or = 2'd1,
		op_xor = 2'd2,
		op_nand = 2'd3
	} lb_op_e;

	// select widths
	parameter int cb_sel_w = 3;
	parameter int sb_sel_w = 2;

endpackage
